/* hdl/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// word address into the backing RAM
`define CACHE_ADDR_W 10

`define CACHE_DATA_W 32
`define CACHE_NBYTES 4

// 16 sets, one word per line
`define CACHE_INDEX_W 4
`define CACHE_NSETS (1 << `CACHE_INDEX_W)

// upper address bits are stored as tag
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W)

`define CACHE_NWAYS 4
`define CACHE_NWAYS_W 2

// backing RAM covers the whole word address space
`define CACHE_RAM_DEPTH (1 << `CACHE_ADDR_W)

`endif

/* hdl/cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

   typedef logic [`CACHE_ADDR_W-1:0]  addr_t;
   typedef logic [`CACHE_DATA_W-1:0]  data_t;
   typedef logic [`CACHE_NBYTES-1:0]  strb_t;
   typedef logic [`CACHE_INDEX_W-1:0] index_t;
   typedef logic [`CACHE_TAG_W-1:0]   tag_t;
   typedef logic [`CACHE_NWAYS_W-1:0] way_t;
   typedef logic [`CACHE_NWAYS-1:0]   ways_vec_t;

   // front-end controller sequencing
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      RESOLVE,
      FETCH,
      REFILL,
      WRITE
   } ctrl_state_t;

endpackage

/* hdl/be_ram.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module be_ram (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             req_i,
   input  cache_pkg::addr_t addr_i,
   input  cache_pkg::data_t wdata_i,
   input  cache_pkg::strb_t wstrb_i,
   output cache_pkg::data_t rdata_o,
   output logic             ack_o
);

   cache_pkg::data_t mem [`CACHE_RAM_DEPTH];

   initial begin
      for (int i = 0; i < `CACHE_RAM_DEPTH; i++)
         mem[i] = '0;
   end

   always_ff @(posedge clk_i) begin
      if (req_i) begin
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (wstrb_i[b])
               mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
         end
         // zero strobe is a read
         if (wstrb_i == '0)
            rdata_o <= mem[addr_i];
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i)
         ack_o <= 1'b0;
      else
         ack_o <= req_i;
   end

endmodule

/* hdl/cache_way.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_way (
   input  logic              clk_i,
   input  logic              rst_i,
   input  cache_pkg::index_t rd_index_i,
   input  logic              we_i,
   input  cache_pkg::index_t wr_index_i,
   input  cache_pkg::tag_t   wr_tag_i,
   input  cache_pkg::data_t  wr_data_i,
   input  cache_pkg::strb_t  wr_strb_i,
   input  logic              fill_i,
   input  logic              inval_all_i,
   output logic              valid_o,
   output cache_pkg::tag_t   tag_o,
   output cache_pkg::data_t  data_o
);

   logic [`CACHE_NSETS-1:0] valid_q;
   cache_pkg::tag_t         tag_mem  [`CACHE_NSETS];
   cache_pkg::data_t        data_mem [`CACHE_NSETS];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid_q <= '0;
         valid_o <= 1'b0;
      end else begin
         if (inval_all_i)
            valid_q <= '0;
         else if (we_i && fill_i)
            valid_q[wr_index_i] <= 1'b1;
         valid_o <= valid_q[rd_index_i];
      end
   end

   always_ff @(posedge clk_i) begin
      if (we_i && fill_i)
         tag_mem[wr_index_i] <= wr_tag_i;
      // merge by byte, a fill has every strobe set
      if (we_i) begin
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (wr_strb_i[b])
               data_mem[wr_index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
         end
      end
      tag_o  <= tag_mem[rd_index_i];
      data_o <= data_mem[rd_index_i];
   end

   // plain writes only happen on a hit
   a_write_hits_valid: assert property (@(posedge clk_i) disable iff (rst_i)
      (we_i && !fill_i) |-> valid_q[wr_index_i]);

endmodule

/* hdl/way_select.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module way_select (
   input  logic                                    clk_i,
   input  logic                                    rst_i,
   input  cache_pkg::ways_vec_t                    valid_i,
   input  cache_pkg::tag_t  [`CACHE_NWAYS-1:0]     tags_i,
   input  cache_pkg::data_t [`CACHE_NWAYS-1:0]     datas_i,
   input  cache_pkg::tag_t                         lookup_tag_i,
   input  logic                                    fill_done_i,
   input  cache_pkg::index_t                       fill_index_i,
   output logic                                    hit_o,
   output cache_pkg::way_t                         hit_way_o,
   output cache_pkg::data_t                        hit_data_o,
   output cache_pkg::way_t                         victim_way_o
);

   cache_pkg::ways_vec_t hit_vec;
   cache_pkg::way_t      rr_q [`CACHE_NSETS];

   // parallel tag compare
   always_comb begin
      for (int w = 0; w < `CACHE_NWAYS; w++)
         hit_vec[w] = valid_i[w] && (tags_i[w] == lookup_tag_i);
   end

   assign hit_o = |hit_vec;

   always_comb begin
      hit_way_o  = '0;
      hit_data_o = '0;
      for (int w = 0; w < `CACHE_NWAYS; w++) begin
         if (hit_vec[w]) begin
            hit_way_o  = cache_pkg::way_t'(w);
            hit_data_o = datas_i[w];
         end
      end
   end

   // round-robin pointer per set
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         for (int s = 0; s < `CACHE_NSETS; s++)
            rr_q[s] <= '0;
      end else if (fill_done_i) begin
         rr_q[fill_index_i] <= rr_q[fill_index_i] + 1'b1;
      end
   end

   assign victim_way_o = rr_q[fill_index_i];

   // the controller never fills a tag that already hits
   a_single_hit: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(hit_vec));

endmodule

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_ctrl (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 req_i,
   input  cache_pkg::addr_t     addr_i,
   input  cache_pkg::data_t     wdata_i,
   input  cache_pkg::strb_t     wstrb_i,
   input  logic                 invalidate_i,
   input  logic                 hit_i,
   input  cache_pkg::way_t      hit_way_i,
   input  cache_pkg::data_t     hit_data_i,
   input  cache_pkg::way_t      victim_way_i,
   input  logic                 be_ack_i,
   input  cache_pkg::data_t     be_rdata_i,
   output logic                 ack_o,
   output cache_pkg::data_t     rdata_o,
   output cache_pkg::index_t    rd_index_o,
   output cache_pkg::tag_t      lookup_tag_o,
   output cache_pkg::ways_vec_t way_we_o,
   output cache_pkg::index_t    wr_index_o,
   output cache_pkg::tag_t      wr_tag_o,
   output cache_pkg::data_t     wr_data_o,
   output cache_pkg::strb_t     wr_strb_o,
   output logic                 fill_o,
   output logic                 inval_all_o,
   output logic                 fill_done_o,
   output logic                 be_req_o,
   output cache_pkg::addr_t     be_addr_o,
   output cache_pkg::data_t     be_wdata_o,
   output cache_pkg::strb_t     be_wstrb_o
);

   cache_pkg::ctrl_state_t state_q;
   cache_pkg::ctrl_state_t state_d;
   cache_pkg::addr_t       addr_q;
   cache_pkg::data_t       wdata_q;
   cache_pkg::strb_t       wstrb_q;
   cache_pkg::way_t        victim_q;
   cache_pkg::data_t       fill_data_q;
   cache_pkg::tag_t        tag;
   cache_pkg::index_t      index;
   logic                   write_q;
   logic                   be_req_q;
   logic                   be_done_q;

   assign tag     = addr_q[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
   assign index   = addr_q[`CACHE_INDEX_W-1:0];
   assign write_q = |wstrb_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         cache_pkg::IDLE:    if (req_i) state_d = cache_pkg::LOOKUP;
         cache_pkg::LOOKUP:  state_d = cache_pkg::RESOLVE;
         cache_pkg::RESOLVE: begin
            if (write_q)
               state_d = cache_pkg::WRITE;
            else if (hit_i)
               state_d = cache_pkg::IDLE;
            else
               state_d = cache_pkg::FETCH;
         end
         cache_pkg::FETCH:   if (be_ack_i) state_d = cache_pkg::REFILL;
         cache_pkg::REFILL:  state_d = cache_pkg::IDLE;
         cache_pkg::WRITE:   if (be_done_q) state_d = cache_pkg::IDLE;
         default:            state_d = cache_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q   <= cache_pkg::IDLE;
         be_req_q  <= 1'b0;
         be_done_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         // writes go out straight from the request, reads only on a miss
         be_req_q <= (state_q == cache_pkg::IDLE && req_i && |wstrb_i) ||
                     (state_q == cache_pkg::RESOLVE && !write_q && !hit_i);
         if (state_q == cache_pkg::IDLE)
            be_done_q <= 1'b0;
         else if (be_ack_i)
            be_done_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == cache_pkg::IDLE && req_i) begin
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
      if (state_q == cache_pkg::RESOLVE)
         victim_q <= victim_way_i;
      if (state_q == cache_pkg::FETCH && be_ack_i)
         fill_data_q <= be_rdata_i;
   end

   assign ack_o = (state_q == cache_pkg::RESOLVE && !write_q && hit_i) ||
                  (state_q == cache_pkg::REFILL) ||
                  (state_q == cache_pkg::WRITE && be_done_q);
   assign rdata_o = (state_q == cache_pkg::REFILL) ? fill_data_q : hit_data_i;

   assign rd_index_o   = index;
   assign lookup_tag_o = tag;

   // hit write in RESOLVE, victim fill in REFILL
   always_comb begin
      way_we_o = '0;
      if (state_q == cache_pkg::RESOLVE && write_q && hit_i)
         way_we_o = cache_pkg::ways_vec_t'(1) << hit_way_i;
      else if (state_q == cache_pkg::REFILL)
         way_we_o = cache_pkg::ways_vec_t'(1) << victim_q;
   end

   assign wr_index_o  = index;
   assign wr_tag_o    = tag;
   assign fill_o      = (state_q == cache_pkg::REFILL);
   assign fill_done_o = (state_q == cache_pkg::REFILL);
   assign wr_data_o   = fill_o ? fill_data_q : wdata_q;
   assign wr_strb_o   = fill_o ? '1 : wstrb_q;
   assign inval_all_o = (state_q == cache_pkg::IDLE) && invalidate_i;

   assign be_req_o   = be_req_q;
   assign be_addr_o  = addr_q;
   assign be_wdata_o = wdata_q;
   assign be_wstrb_o = wstrb_q;

   // the requester must wait for ack_o
   a_req_in_idle: assert property (@(posedge clk_i) disable iff (rst_i)
      req_i |-> state_q == cache_pkg::IDLE);

   // backing RAM answers the next cycle
   a_be_ack: assert property (@(posedge clk_i) disable iff (rst_i)
      be_req_o |=> be_ack_i);

endmodule

/* hdl/cache_top.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_top (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             req_i,
   input  cache_pkg::addr_t addr_i,
   input  cache_pkg::data_t wdata_i,
   input  cache_pkg::strb_t wstrb_i,
   input  logic             invalidate_i,
   output cache_pkg::data_t rdata_o,
   output logic             ack_o
);

   logic                                hit;
   cache_pkg::way_t                     hit_way;
   cache_pkg::data_t                    hit_data;
   cache_pkg::way_t                     victim_way;
   cache_pkg::index_t                   rd_index;
   cache_pkg::tag_t                     lookup_tag;
   cache_pkg::ways_vec_t                way_we;
   cache_pkg::index_t                   wr_index;
   cache_pkg::tag_t                     wr_tag;
   cache_pkg::data_t                    wr_data;
   cache_pkg::strb_t                    wr_strb;
   logic                                fill;
   logic                                inval_all;
   logic                                fill_done;
   cache_pkg::ways_vec_t                way_valid;
   cache_pkg::tag_t  [`CACHE_NWAYS-1:0] way_tags;
   cache_pkg::data_t [`CACHE_NWAYS-1:0] way_datas;
   logic                                be_req;
   logic                                be_ack;
   cache_pkg::addr_t                    be_addr;
   cache_pkg::data_t                    be_wdata;
   cache_pkg::strb_t                    be_wstrb;
   cache_pkg::data_t                    be_rdata;

   cache_ctrl i_cache_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (req_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .wstrb_i      (wstrb_i),
      .invalidate_i (invalidate_i),
      .hit_i        (hit),
      .hit_way_i    (hit_way),
      .hit_data_i   (hit_data),
      .victim_way_i (victim_way),
      .be_ack_i     (be_ack),
      .be_rdata_i   (be_rdata),
      .ack_o        (ack_o),
      .rdata_o      (rdata_o),
      .rd_index_o   (rd_index),
      .lookup_tag_o (lookup_tag),
      .way_we_o     (way_we),
      .wr_index_o   (wr_index),
      .wr_tag_o     (wr_tag),
      .wr_data_o    (wr_data),
      .wr_strb_o    (wr_strb),
      .fill_o       (fill),
      .inval_all_o  (inval_all),
      .fill_done_o  (fill_done),
      .be_req_o     (be_req),
      .be_addr_o    (be_addr),
      .be_wdata_o   (be_wdata),
      .be_wstrb_o   (be_wstrb)
   );

   for (genvar w = 0; w < `CACHE_NWAYS; w++) begin : g_way
      cache_way i_cache_way (
         .clk_i       (clk_i),
         .rst_i       (rst_i),
         .rd_index_i  (rd_index),
         .we_i        (way_we[w]),
         .wr_index_i  (wr_index),
         .wr_tag_i    (wr_tag),
         .wr_data_i   (wr_data),
         .wr_strb_i   (wr_strb),
         .fill_i      (fill),
         .inval_all_i (inval_all),
         .valid_o     (way_valid[w]),
         .tag_o       (way_tags[w]),
         .data_o      (way_datas[w])
      );
   end

   // victim pointer follows the index held by the controller
   way_select i_way_select (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .valid_i      (way_valid),
      .tags_i       (way_tags),
      .datas_i      (way_datas),
      .lookup_tag_i (lookup_tag),
      .fill_done_i  (fill_done),
      .fill_index_i (wr_index),
      .hit_o        (hit),
      .hit_way_o    (hit_way),
      .hit_data_o   (hit_data),
      .victim_way_o (victim_way)
   );

   be_ram i_be_ram (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (be_req),
      .addr_i  (be_addr),
      .wdata_i (be_wdata),
      .wstrb_i (be_wstrb),
      .rdata_o (be_rdata),
      .ack_o   (be_ack)
   );

endmodule

/* verification/tb_cache_top.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module tb_cache_top;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 5;
   localparam int ACK_LIMIT    = 12;
   localparam int NUM_RANDOM   = 400;
   localparam int NUM_STRB     = 8;
   localparam int NUM_LAT      = 8;
   localparam int NUM_INVAL    = 8;
   // requests issued by each test, in order
   localparam int TOTAL_REQS = NUM_RANDOM + 7 * NUM_STRB + 4 * NUM_LAT +
                               2 * (`CACHE_NWAYS + 1) + 2 + 5 * NUM_INVAL;
   localparam int WATCHDOG_CYCLES = TOTAL_REQS * 10 + RESET_CYCLES + 100;

   logic             clk_i;
   logic             rst_i;
   logic             req_i;
   cache_pkg::addr_t addr_i;
   cache_pkg::data_t wdata_i;
   cache_pkg::strb_t wstrb_i;
   logic             invalidate_i;
   cache_pkg::data_t rdata_o;
   logic             ack_o;

   // reference RAM contents and expected cache contents
   cache_pkg::data_t model_mem    [`CACHE_RAM_DEPTH];
   cache_pkg::tag_t  mirror_tag   [`CACHE_NSETS][`CACHE_NWAYS];
   logic             mirror_valid [`CACHE_NSETS][`CACHE_NWAYS];
   int               mirror_ptr   [`CACHE_NSETS];

   int error_count;
   int check_count;
   int test_count;
   int failed_tests;
   int test_start_errors;
   int seed_init;

   cache_top i_cache_top (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (req_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .wstrb_i      (wstrb_i),
      .invalidate_i (invalidate_i),
      .rdata_o      (rdata_o),
      .ack_o        (ack_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   function automatic cache_pkg::addr_t make_addr(input int tag_val, input int index_val);
      return {cache_pkg::tag_t'(tag_val), cache_pkg::index_t'(index_val)};
   endfunction

   function automatic logic mirror_hit(input cache_pkg::addr_t addr);
      int              idx;
      cache_pkg::tag_t tag;
      logic            found;
      idx   = addr[`CACHE_INDEX_W-1:0];
      tag   = addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
      found = 1'b0;
      for (int w = 0; w < `CACHE_NWAYS; w++) begin
         if (mirror_valid[idx][w] && mirror_tag[idx][w] == tag)
            found = 1'b1;
      end
      return found;
   endfunction

   // write 3, read hit 2, read miss 5
   function automatic int predict_latency(input cache_pkg::addr_t addr,
                                          input cache_pkg::strb_t strb);
      if (strb != '0)
         return 3;
      return mirror_hit(addr) ? 2 : 5;
   endfunction

   function automatic cache_pkg::data_t merge_bytes(input cache_pkg::data_t old_word,
                                                    input cache_pkg::data_t new_word,
                                                    input cache_pkg::strb_t strb);
      cache_pkg::data_t result;
      result = old_word;
      for (int b = 0; b < `CACHE_NBYTES; b++) begin
         if (strb[b])
            result[b*8 +: 8] = new_word[b*8 +: 8];
      end
      return result;
   endfunction

   // no write allocate, a read miss fills the round-robin victim
   task automatic update_reference(input cache_pkg::addr_t addr, input cache_pkg::data_t wdata,
                                   input cache_pkg::strb_t wstrb);
      int idx;
      idx = addr[`CACHE_INDEX_W-1:0];
      if (wstrb != '0) begin
         model_mem[addr] = merge_bytes(model_mem[addr], wdata, wstrb);
      end else if (!mirror_hit(addr)) begin
         mirror_tag[idx][mirror_ptr[idx]]   = addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
         mirror_valid[idx][mirror_ptr[idx]] = 1'b1;
         mirror_ptr[idx] = (mirror_ptr[idx] + 1) % `CACHE_NWAYS;
      end
   endtask

   task automatic issue_request(input cache_pkg::addr_t addr, input cache_pkg::data_t wdata,
                                input cache_pkg::strb_t wstrb, input int exp_lat);
      int               lat;
      logic             acked;
      cache_pkg::data_t got_data;
      lat      = 0;
      acked    = 1'b0;
      got_data = '0;
      @(negedge clk_i);
      req_i   = 1'b1;
      addr_i  = addr;
      wdata_i = wdata;
      wstrb_i = wstrb;
      while (!acked && lat < ACK_LIMIT) begin
         @(negedge clk_i);
         req_i = 1'b0;
         lat++;
         if (ack_o) begin
            acked    = 1'b1;
            got_data = rdata_o;
         end
      end
      check_count++;
      assert (acked) else begin
         $display("time %0d ns: no ack_o within %0d cycles for the request to address %h",
                  $time, ACK_LIMIT, addr);
         error_count++;
      end
      if (acked) begin
         check_count++;
         assert (lat == exp_lat) else begin
            $display("[ERROR] time %0d ns: ack_o latency at address %h expected %0d actual %0d",
                     $time, addr, exp_lat, lat);
            error_count++;
         end
         if (wstrb == '0) begin
            check_count++;
            assert (got_data == model_mem[addr]) else begin
               $display("[ERROR] time %0d ns: rdata_o at address %h expected %h actual %h",
                        $time, addr, model_mem[addr], got_data);
               error_count++;
            end
         end
      end
      update_reference(addr, wdata, wstrb);
   endtask

   task automatic pulse_invalidate();
      @(negedge clk_i);
      invalidate_i = 1'b1;
      @(negedge clk_i);
      invalidate_i = 1'b0;
      // victim pointers survive an invalidate
      for (int s = 0; s < `CACHE_NSETS; s++) begin
         for (int w = 0; w < `CACHE_NWAYS; w++)
            mirror_valid[s][w] = 1'b0;
      end
   endtask

   task automatic finish_test(input string name);
      int errs;
      errs = error_count - test_start_errors;
      test_count++;
      if (errs == 0) begin
         $display("test %s: PASS", name);
      end else begin
         failed_tests++;
         $display("test %s: FAIL with %0d errors", name, errs);
      end
      test_start_errors = error_count;
   endtask

   task automatic random_traffic();
      cache_pkg::addr_t addr;
      cache_pkg::data_t data;
      cache_pkg::strb_t strb;
      for (int n = 0; n < NUM_RANDOM; n++) begin
         // 6 tags over 4 sets keeps evictions frequent
         addr = make_addr($urandom_range(5, 0), $urandom_range(3, 0));
         data = $urandom;
         strb = '0;
         if ($urandom_range(1, 0) == 1)
            strb = cache_pkg::strb_t'($urandom_range((1 << `CACHE_NBYTES) - 1, 1));
         issue_request(addr, data, strb, predict_latency(addr, strb));
      end
      finish_test("random_traffic");
   endtask

   task automatic partial_strobe_merge();
      cache_pkg::addr_t addr;
      cache_pkg::strb_t strb;
      for (int i = 0; i < NUM_STRB; i++) begin
         // line held, write merges into the way
         addr = make_addr(48 + i, i);
         strb = cache_pkg::strb_t'($urandom_range((1 << `CACHE_NBYTES) - 2, 1));
         issue_request(addr, $urandom, '1, 3);
         issue_request(addr, '0, '0, 5);
         issue_request(addr, $urandom, strb, 3);
         issue_request(addr, '0, '0, 2);
         // line not held, merged word comes back from RAM
         addr = make_addr(32 + i, 8 + i);
         strb = cache_pkg::strb_t'($urandom_range((1 << `CACHE_NBYTES) - 2, 1));
         issue_request(addr, $urandom, '1, 3);
         issue_request(addr, $urandom, strb, 3);
         issue_request(addr, '0, '0, 5);
      end
      finish_test("partial_strobe_merge");
   endtask

   task automatic latency_sweep();
      cache_pkg::addr_t addr;
      for (int i = 0; i < NUM_LAT; i++) begin
         addr = make_addr(60 + i % 4, i);
         issue_request(addr, '0, '0, 5);
         issue_request(addr, '0, '0, 2);
         issue_request(addr, $urandom, '1, 3);
         issue_request(addr, '0, '0, 2);
      end
      finish_test("latency_sweep");
   endtask

   task automatic set_eviction();
      for (int t = 0; t <= `CACHE_NWAYS; t++)
         issue_request(make_addr(16 + t, 9), $urandom, '1, 3);
      for (int t = 0; t <= `CACHE_NWAYS; t++)
         issue_request(make_addr(16 + t, 9), '0, '0, 5);
      // oldest fill is gone, newest one stays
      issue_request(make_addr(16, 9), '0, '0, 5);
      issue_request(make_addr(16 + `CACHE_NWAYS, 9), '0, '0, 2);
      finish_test("set_eviction");
   endtask

   task automatic invalidate_all();
      cache_pkg::addr_t addr;
      for (int i = 0; i < NUM_INVAL; i++) begin
         addr = make_addr(8 + i, i);
         issue_request(addr, $urandom, '1, 3);
         issue_request(addr, '0, '0, predict_latency(addr, '0));
         issue_request(addr, '0, '0, 2);
      end
      pulse_invalidate();
      for (int i = 0; i < NUM_INVAL; i++) begin
         addr = make_addr(8 + i, i);
         issue_request(addr, '0, '0, 5);
         issue_request(addr, '0, '0, 2);
      end
      finish_test("invalidate_all");
   endtask

   initial begin
      seed_init         = $urandom(68);
      clk_i             = 1'b0;
      rst_i             = 1'b1;
      req_i             = 1'b0;
      addr_i            = '0;
      wdata_i           = '0;
      wstrb_i           = '0;
      invalidate_i      = 1'b0;
      error_count       = 0;
      check_count       = 0;
      test_count        = 0;
      failed_tests      = 0;
      test_start_errors = 0;
      for (int i = 0; i < `CACHE_RAM_DEPTH; i++)
         model_mem[i] = '0;
      for (int s = 0; s < `CACHE_NSETS; s++) begin
         mirror_ptr[s] = 0;
         for (int w = 0; w < `CACHE_NWAYS; w++) begin
            mirror_valid[s][w] = 1'b0;
            mirror_tag[s][w]   = '0;
         end
      end
      repeat (RESET_CYCLES) @(negedge clk_i);
      rst_i = 1'b0;
      random_traffic();
      partial_strobe_merge();
      latency_sweep();
      set_eviction();
      invalidate_all();
      @(negedge clk_i);
      $display("%0d tests run, %0d failed, %0d checks, %0d errors",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
      $display("Test failures found");
      $finish;
   end

endmodule

/* flist.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/be_ram.sv
hdl/cache_way.sv
hdl/way_select.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
verification/tb_cache_top.sv

/* Bender.yml */
package:
  name: cache_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cache_pkg.sv
      - hdl/be_ram.sv
      - hdl/cache_way.sv
      - hdl/way_select.sv
      - hdl/cache_ctrl.sv
      - hdl/cache_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_cache_top.sv
